// File: rtl/trs_io_settings.svh
`ifndef TRS_IO_SETTINGS_SVH
`define TRS_IO_SETTINGS_SVH

// identification byte for get_cookie
`define TRS_IO_COOKIE         8'hAF

// firmware version, packed as {major, minor} in the reply byte
`define TRS_IO_VERSION_MAJOR  3'd0
`define TRS_IO_VERSION_MINOR  5'd3

// model III io ports
`define TRS_IO_PORT           8'h1F   // trs-io data port
`define TRS_IO_FREHD_HI       4'hC    // frehd block C0h-CFh

// esp_req pulse length in clk cycles
`define TRS_IO_REQ_CYCLES     50

// status code while no port is selected
`define TRS_IO_ESP_S_IDLE     4'hF

`endif

// File: rtl/trs_bus_pkg.sv
`default_nettype none

package trs_bus_pkg;

  // z80 address and data as seen at the expansion connector
  typedef logic [15:0] trs_addr_t;
  typedef logic [7:0]  trs_data_t;

  // bus inputs, all strobes active low
  typedef struct packed {
    trs_addr_t addr;
    trs_data_t data_in;
    logic      in_n;
    logic      out_n;
    logic      ioreq_n;
  } trs_bus_t;

  // codes on the esp_s lines, tells the esp which access is pending
  typedef enum logic [3:0] {
    trs_io_in  = 4'd0,
    trs_io_out = 4'd1,
    frehd_in   = 4'd2,
    frehd_out  = 4'd3
  } esp_sel_t;

endpackage

`default_nettype wire

// File: rtl/esp_cmd_pkg.sv
`default_nettype none

package esp_cmd_pkg;

  typedef logic [7:0] spi_byte_t;

  // opcodes sent by the esp, numbering kept compatible with its firmware
  typedef enum logic [7:0] {
    get_cookie     = 8'd0,
    dbus_write     = 8'd4,
    data_ready     = 8'd5,
    get_version    = 8'd15,
    set_led        = 8'd26,
    get_config     = 8'd27,
    set_esp_status = 8'd32
  } cmd_op_t;

  typedef enum logic {
    idle,
    read_params
  } parse_state_t;

  // one decoded command, params[0] is the first byte after the opcode
  typedef struct packed {
    cmd_op_t         op;
    spi_byte_t [2:0] params;
  } cmd_frame_t;

endpackage

`default_nettype wire

// File: rtl/spi_slave.sv
`timescale 1ns/1ps
`default_nettype none

module spi_slave (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   cs_n,
  input  wire logic                   sck,
  input  wire logic                   mosi,
  input  wire esp_cmd_pkg::spi_byte_t reply,
  output logic                        miso,
  output esp_cmd_pkg::spi_byte_t      rx_byte,
  output logic                        rx_valid
);
  import esp_cmd_pkg::*;

  logic [2:0] sck_sync;   // two sync stages, third for edge detect
  logic [1:0] cs_sync;
  logic [1:0] mosi_sync;
  logic [2:0] bit_cnt;
  spi_byte_t  rx_shift;
  spi_byte_t  tx_shift;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;

  assign sck_rise  = (sck_sync[2:1] == 2'b01);
  assign sck_fall  = (sck_sync[2:1] == 2'b10);
  assign cs_active = ~cs_sync[1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sck_sync  <= '0;
      cs_sync   <= 2'b11;   // deselected
      mosi_sync <= '0;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      cs_sync   <= {cs_sync[0], cs_n};
      mosi_sync <= {mosi_sync[0], mosi};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= '0;   // realign on every deselect
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7)
          rx_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cs_active && sck_rise)
      rx_shift <= {rx_shift[6:0], mosi_sync[1]};   // msb first
    if (bit_cnt == 3'd0 && !sck_sync[1])
      tx_shift <= reply;   // between bytes, follow the reply
    else if (sck_fall)
      tx_shift <= {tx_shift[6:0], 1'b0};
  end

  assign rx_byte = rx_shift;
  assign miso    = tx_shift[7];

endmodule

`default_nettype wire

// File: rtl/cmd_parser.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_parser (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire esp_cmd_pkg::spi_byte_t rx_byte,
  input  wire logic                   rx_valid,
  output esp_cmd_pkg::cmd_frame_t     frame,
  output logic                        cmd_valid
);
  import esp_cmd_pkg::*;

  parse_state_t state;
  logic [1:0]   params_left;
  logic [1:0]   param_idx;
  logic         op_known;
  logic [1:0]   op_params;

  // parameter count of the incoming opcode
  always_comb begin
    op_known  = 1'b1;
    op_params = 2'd0;
    case (rx_byte)
      set_led, set_esp_status, dbus_write:
        op_params = 2'd1;
      get_cookie, get_version, get_config, data_ready:
        op_params = 2'd0;
      default:
        op_known = 1'b0;   // unknown opcode, ignored
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= idle;
      params_left <= '0;
      param_idx   <= '0;
      cmd_valid   <= 1'b0;
    end else begin
      cmd_valid <= 1'b0;
      if (rx_valid) begin
        case (state)
          idle: begin
            param_idx   <= '0;
            params_left <= op_params;
            if (op_known && op_params == 2'd0)
              cmd_valid <= 1'b1;
            else if (op_known)
              state <= read_params;
          end
          read_params: begin
            param_idx   <= param_idx + 2'd1;
            params_left <= params_left - 2'd1;
            if (params_left == 2'd1) begin
              cmd_valid <= 1'b1;   // last parameter in
              state     <= idle;
            end
          end
          default: state <= idle;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid) begin
      if (state == idle && op_known) begin
        frame.op     <= cmd_op_t'(rx_byte);
        frame.params <= '0;
      end else if (state == read_params) begin
        frame.params[param_idx] <= rx_byte;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/cmd_exec.sv
`timescale 1ns/1ps
`include "trs_io_settings.svh"
`default_nettype none

module cmd_exec (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire esp_cmd_pkg::cmd_frame_t frame,
  input  wire logic                    cmd_valid,
  input  wire logic [3:0]              conf,
  output esp_cmd_pkg::spi_byte_t       reply,
  output logic [2:0]                   led_rgb,
  output logic                         esp_ready,
  output trs_bus_pkg::trs_data_t       dbus_data,
  output logic                         data_ready_set
);
  import esp_cmd_pkg::*;

  // bit 0 esp ready, bit 1 wifi up, bit 2 smb mounted, bit 3 sd mounted
  spi_byte_t esp_status;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reply          <= '0;
      led_rgb        <= '0;
      esp_status     <= '0;
      data_ready_set <= 1'b0;
    end else begin
      data_ready_set <= 1'b0;
      if (cmd_valid) begin
        case (frame.op)
          get_cookie:     reply <= `TRS_IO_COOKIE;
          get_version:    reply <= {`TRS_IO_VERSION_MAJOR, `TRS_IO_VERSION_MINOR};
          get_config:     reply <= {4'h0, conf};
          set_led:        led_rgb <= frame.params[0][2:0];   // red, green, blue
          set_esp_status: esp_status <= frame.params[0];
          data_ready:     data_ready_set <= 1'b1;
          default: begin
          end
        endcase
      end
    end
  end

  // byte handed to the z80 on its next in cycle
  always_ff @(posedge clk) begin
    if (cmd_valid && frame.op == dbus_write)
      dbus_data <= frame.params[0];
  end

  assign esp_ready = esp_status[0];

endmodule

`default_nettype wire

// File: rtl/esp_bridge.sv
`timescale 1ns/1ps
`include "trs_io_settings.svh"
`default_nettype none

module esp_bridge (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire trs_bus_pkg::trs_bus_t  bus,
  input  wire logic                   esp_done,
  input  wire trs_bus_pkg::trs_data_t dbus_data,
  input  wire logic                   data_ready_set,
  output trs_bus_pkg::trs_data_t      d_out,
  output logic                        d_oe,
  output logic                        wait_out,
  output logic                        esp_req,
  output trs_bus_pkg::esp_sel_t       esp_s,
  output logic                        extiosel,
  output logic                        int_req,
  output logic                        port_sel
);
  import trs_bus_pkg::*;

  logic       io_in;    // in cycle, qualified by ioreq_n
  logic       io_out;
  logic       hit_trs_io;
  logic       hit_frehd;
  logic       sel_trs_io_in;
  logic       sel_trs_io_out;
  logic       sel_frehd_in;
  logic       sel_frehd_out;
  logic       sel_in;
  logic [2:0] acc_sync;
  logic       esp_access;   // first clk of a decoded port cycle
  logic [2:0] done_sync;
  logic       done_rise;
  logic [5:0] req_cnt;

  assign io_in  = ~(bus.in_n | bus.ioreq_n);
  assign io_out = ~(bus.out_n | bus.ioreq_n);

  // model III decodes only the low address byte for io
  assign hit_trs_io = (bus.addr[7:0] == `TRS_IO_PORT);
  assign hit_frehd  = (bus.addr[7:4] == `TRS_IO_FREHD_HI);

  assign sel_trs_io_in  = hit_trs_io & io_in;
  assign sel_trs_io_out = hit_trs_io & io_out;
  assign sel_frehd_in   = hit_frehd & io_in;
  assign sel_frehd_out  = hit_frehd & io_out;
  assign sel_in         = sel_trs_io_in | sel_frehd_in;
  assign port_sel       = sel_in | sel_trs_io_out | sel_frehd_out;

  assign esp_access = (acc_sync[2:1] == 2'b01) & port_sel;
  assign done_rise  = (done_sync[2:1] == 2'b01);

  always_comb begin
    if (sel_trs_io_in)
      esp_s = trs_io_in;
    else if (sel_trs_io_out)
      esp_s = trs_io_out;
    else if (sel_frehd_in)
      esp_s = frehd_in;
    else if (sel_frehd_out)
      esp_s = frehd_out;
    else
      esp_s = esp_sel_t'(`TRS_IO_ESP_S_IDLE);
  end

  // card answers in cycles to its own ports
  assign d_oe     = sel_in;
  assign extiosel = sel_in;
  assign d_out    = sel_in ? dbus_data : '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc_sync  <= '0;
      done_sync <= '0;
      wait_out  <= 1'b0;
      req_cnt   <= '0;
      int_req   <= 1'b0;
    end else begin
      acc_sync  <= {acc_sync[1:0], io_in | io_out};
      done_sync <= {done_sync[1:0], esp_done};

      if (esp_access)
        wait_out <= 1'b1;   // hold the z80 until the esp has answered
      else if (done_rise)
        wait_out <= 1'b0;

      if (esp_access)
        req_cnt <= 6'(`TRS_IO_REQ_CYCLES);
      else if (req_cnt != '0)
        req_cnt <= req_cnt - 6'd1;

      if (data_ready_set)
        int_req <= 1'b1;
      else if (esp_access && (sel_trs_io_in || sel_trs_io_out))
        int_req <= 1'b0;   // acknowledged by the trs-io port access
    end
  end

  assign esp_req = (req_cnt != '0);

endmodule

`default_nettype wire

// File: rtl/trs_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module trs_io_top (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire trs_bus_pkg::trs_bus_t bus,
  input  wire logic                  esp_done,
  input  wire logic [3:0]            conf,
  input  wire logic                  spi_cs_n,
  input  wire logic                  spi_sck,
  input  wire logic                  spi_mosi,
  output logic                       spi_miso,
  output trs_bus_pkg::trs_data_t     d_out,
  output logic                       d_oe,
  output logic                       wait_out,
  output logic                       int_req,
  output logic                       extiosel,
  output logic                       esp_req,
  output trs_bus_pkg::esp_sel_t      esp_s,
  output logic [2:0]                 led_rgb,
  output logic [2:0]                 led
);
  import trs_bus_pkg::*;
  import esp_cmd_pkg::*;

  spi_byte_t  rx_byte;
  logic       rx_valid;
  spi_byte_t  reply;
  cmd_frame_t frame;
  logic       cmd_valid;
  trs_data_t  dbus_data;
  logic       data_ready_set;
  logic       esp_ready;
  logic       port_sel;

  spi_slave u_spi_slave (
    .clk(clk), .rst_n(rst_n), .cs_n(spi_cs_n), .sck(spi_sck), .mosi(spi_mosi),
    .reply(reply), .miso(spi_miso), .rx_byte(rx_byte), .rx_valid(rx_valid)
  );

  cmd_parser u_cmd_parser (
    .clk(clk), .rst_n(rst_n), .rx_byte(rx_byte), .rx_valid(rx_valid),
    .frame(frame), .cmd_valid(cmd_valid)
  );

  cmd_exec u_cmd_exec (
    .clk(clk), .rst_n(rst_n), .frame(frame), .cmd_valid(cmd_valid), .conf(conf),
    .reply(reply), .led_rgb(led_rgb), .esp_ready(esp_ready),
    .dbus_data(dbus_data), .data_ready_set(data_ready_set)
  );

  esp_bridge u_esp_bridge (
    .clk(clk), .rst_n(rst_n), .bus(bus), .esp_done(esp_done),
    .dbus_data(dbus_data), .data_ready_set(data_ready_set),
    .d_out(d_out), .d_oe(d_oe), .wait_out(wait_out), .esp_req(esp_req),
    .esp_s(esp_s), .extiosel(extiosel), .int_req(int_req), .port_sel(port_sel)
  );

  // status leds: wait, port selected, esp ready
  assign led = {esp_ready, port_sel, wait_out};

endmodule

`default_nettype wire

// File: tb/tb_trs_io_tasks.svh
`ifndef TB_TRS_IO_TASKS_SVH
`define TB_TRS_IO_TASKS_SVH

int         err_count;
int         test_errs;
int         tests_failed;
logic       saw_wait;
int         wait_lat;      // clk edges from strobe to wait_out
int         req_len;       // clk cycles with esp_req high
int         rel_lat;       // clk edges from esp_done to wait_out low
logic [3:0] s_during;
logic [3:0] s_after;
logic       oe_during;
logic       xsel_during;
trs_data_t  dout_during;
logic [2:0] led_during;
logic [2:0] led_waiting;   // status leds once wait_out is up
logic [2:0] led_after;

task automatic step(input int n);
  repeat (n) begin
    @(posedge clk);
    #1;
  end
endtask

task automatic mismatch(input string msg);
  err_count++;
  test_errs++;
  $display("MISMATCH at %0t ns: %s", $time, msg);
endtask

task automatic fault(input string msg);
  err_count++;
  test_errs++;
  $display("error at %0t ns: %s", $time, msg);
endtask

task automatic end_test(input int num, input string name);
  if (test_errs == 0) begin
    $display("test %0d %s: ok", num, name);
  end else begin
    $display("test %0d %s: %0d errors", num, name, test_errs);
    tests_failed++;
  end
  test_errs = 0;
endtask

// one byte, mode 0 style, host changes mosi while sck is low
task automatic spi_byte(input spi_byte_t tx, output spi_byte_t rx);
  for (int i = 7; i >= 0; i--) begin
    spi_mosi = tx[i];
    step(spi_half);
    spi_sck = 1'b1;
    step(spi_half);
    rx[i] = spi_miso;   // late in the high phase
    spi_sck = 1'b0;
  end
  step(spi_gap);
endtask

// opcode plus one byte, the second byte is a dummy for queries
task automatic spi_cmd(input spi_byte_t op, input spi_byte_t arg, output spi_byte_t rx);
  spi_byte_t first;
  spi_cs_n = 1'b0;
  step(4);
  spi_byte(op, first);
  spi_byte(arg, rx);
  spi_cs_n = 1'b1;
  step(4);
endtask

// full z80 io cycle, esp side answers with esp_done once esp_req has ended
task automatic io_cycle(input logic [7:0] port, input logic is_in);
  int n;
  bus.addr    = {8'($random(seed)), port};
  bus.data_in = 8'($random(seed));
  bus.ioreq_n = 1'b0;
  bus.in_n    = ~is_in;
  bus.out_n   = is_in;
  step(1);
  n           = 1;
  s_during    = esp_s;
  oe_during   = d_oe;
  xsel_during = extiosel;
  dout_during = d_out;
  led_during  = led;
  while (!wait_out && n < 8) begin
    step(1);
    n++;
  end
  saw_wait = wait_out;
  wait_lat = n;
  req_len  = 0;
  rel_lat  = 0;
  if (saw_wait) begin
    led_waiting = led;
    while (esp_req && req_len < 100) begin
      req_len++;
      step(1);
    end
    esp_done = 1'b1;
    while (wait_out && rel_lat < 10) begin
      step(1);
      rel_lat++;
    end
    esp_done = 1'b0;
  end
  bus.in_n    = 1'b1;
  bus.out_n   = 1'b1;
  bus.ioreq_n = 1'b1;
  step(1);
  s_after   = esp_s;
  led_after = led;
  step(4);   // let the access and done syncs settle
endtask

`endif

// File: tb/tb_trs_io.sv
`timescale 1ns/1ps
`include "trs_io_settings.svh"
`default_nettype none

module tb_trs_io;
  import trs_bus_pkg::*;
  import esp_cmd_pkg::*;

  localparam int num_tests      = 6;
  localparam int test_budget_ns = 20000;
  localparam int spi_half       = 5;    // clk per sck level
  localparam int spi_gap        = 14;   // clk between bytes

  logic       clk;
  logic       rst_n;
  trs_bus_t   bus;
  logic       esp_done;
  logic [3:0] conf;
  logic       spi_cs_n;
  logic       spi_sck;
  logic       spi_mosi;
  logic       spi_miso;
  trs_data_t  d_out;
  logic       d_oe;
  logic       wait_out;
  logic       int_req;
  logic       extiosel;
  logic       esp_req;
  esp_sel_t   esp_s;
  logic [2:0] led_rgb;
  logic [2:0] led;
  int         seed = 75232;

  trs_io_top UUT (
    .clk(clk), .rst_n(rst_n), .bus(bus), .esp_done(esp_done), .conf(conf),
    .spi_cs_n(spi_cs_n), .spi_sck(spi_sck), .spi_mosi(spi_mosi), .spi_miso(spi_miso),
    .d_out(d_out), .d_oe(d_oe), .wait_out(wait_out), .int_req(int_req),
    .extiosel(extiosel), .esp_req(esp_req), .esp_s(esp_s), .led_rgb(led_rgb), .led(led)
  );

  `include "tb_trs_io_tasks.svh"

  // reference decode: 1Fh gives codes 0/1, C0h-CFh codes 2/3, else idle
  function automatic logic [3:0] exp_sel(input logic [7:0] port, input logic is_in);
    if (port == 8'h1F)
      return is_in ? 4'd0 : 4'd1;
    if (port[7:4] == 4'hC)
      return is_in ? 4'd2 : 4'd3;
    return 4'hF;
  endfunction

  task automatic pick_port(input logic decoded, output logic [7:0] p);
    logic [7:0] r;
    r = 8'($random(seed));
    if (decoded) begin
      p = r[0] ? 8'h1F : {4'hC, r[7:4]};
    end else begin
      p = r;
      while (p == 8'h1F || p[7:4] == 4'hC)
        p = 8'($random(seed));
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #(num_tests * test_budget_ns);
    $display("timeout: tests still running after %0d ns", num_tests * test_budget_ns);
    $display("Regression failed");
    $finish;
  end

  initial begin
    spi_byte_t  rx;
    spi_byte_t  arg;
    logic [7:0] port;
    logic       is_in;
    logic       decoded;
    logic [3:0] exp_s;
    err_count    = 0;
    test_errs    = 0;
    tests_failed = 0;
    rst_n        = 1'b0;
    bus          = '0;
    bus.in_n     = 1'b1;
    bus.out_n    = 1'b1;
    bus.ioreq_n  = 1'b1;
    esp_done     = 1'b0;
    conf         = 4'h0;
    spi_cs_n     = 1'b1;
    spi_sck      = 1'b0;
    spi_mosi     = 1'b0;
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
    step(2);

    // identification
    if (wait_out || esp_req || int_req || d_oe || led_rgb != 3'd0 || led[2] || esp_s != 4'hF)
      mismatch("outputs not idle after reset");
    spi_cmd(get_cookie, 8'hFF, rx);
    if (rx !== `TRS_IO_COOKIE)
      mismatch($sformatf("get_cookie reply %h, expected %h", rx, `TRS_IO_COOKIE));
    spi_cmd(get_version, 8'hFF, rx);
    if (rx[7:5] !== `TRS_IO_VERSION_MAJOR || rx[4:0] !== `TRS_IO_VERSION_MINOR)
      mismatch($sformatf("get_version reply %h", rx));
    repeat (4) begin
      conf = 4'($random(seed));
      spi_cmd(get_config, 8'hFF, rx);
      if (rx[7:4] !== 4'h0 || rx[3:0] !== conf)
        mismatch($sformatf("get_config reply %h, conf %h", rx, conf));
    end
    end_test(1, "identification");

    repeat (20) begin
      arg = 8'($random(seed));
      spi_cmd(set_led, arg, rx);
      if (led_rgb !== arg[2:0])
        mismatch($sformatf("led_rgb %b after set_led %h", led_rgb, arg));
    end
    end_test(2, "leds");

    repeat (8) begin
      arg = 8'($random(seed));
      spi_cmd(set_esp_status, arg, rx);
      if (led[2] !== arg[0])
        mismatch($sformatf("esp ready led %b after status %h", led[2], arg));
    end
    end_test(3, "esp status");

    repeat (16) begin
      is_in   = 1'($random(seed));
      decoded = 1'($random(seed));
      pick_port(decoded, port);
      exp_s = exp_sel(port, is_in);
      io_cycle(port, is_in);
      if (s_during !== exp_s)
        mismatch($sformatf("esp_s %h on port %h in=%b, expected %h",
                           s_during, port, is_in, exp_s));
      if (s_after !== 4'hF)
        mismatch($sformatf("esp_s %h after cycle, expected idle", s_after));
      if (led_during[1:0] !== {decoded, 1'b0})
        mismatch($sformatf("led %b early in the cycle on port %h", led_during, port));
      if (led_after[1:0] !== 2'b00)
        mismatch($sformatf("led %b after cycle, expected wait and select off", led_after));
      if (exp_s != 4'hF) begin
        if (!saw_wait || wait_lat > 4)
          fault($sformatf("wait_out did not rise within 4 clk on port %h", port));
        if (saw_wait && led_waiting[1:0] !== 2'b11)
          mismatch($sformatf("led %b while wait_out is high", led_waiting));
        if (saw_wait && req_len != 50)
          mismatch($sformatf("esp_req high %0d clk, expected 50", req_len));
        if (saw_wait && (wait_out || rel_lat > 5))
          fault("wait_out not released within 5 clk of esp_done");
      end else if (saw_wait || esp_req) begin
        fault($sformatf("undecoded port %h raised wait_out or esp_req", port));
      end
    end
    end_test(4, "port request");

    repeat (4) begin
      arg = 8'($random(seed));
      spi_cmd(dbus_write, arg, rx);
      io_cycle(8'h1F, 1'b1);
      if (!oe_during || !xsel_during || dout_during !== arg)
        mismatch($sformatf("in from 1Fh: oe %b sel %b data %h, expected %h",
                           oe_during, xsel_during, dout_during, arg));
      io_cycle(8'h1F, 1'b0);
      if (oe_during)
        mismatch("d_oe high during an out cycle");
    end
    end_test(5, "bus read data");

    spi_cmd(data_ready, 8'hFF, rx);
    if (int_req !== 1'b1)
      mismatch("int_req low after data_ready");
    io_cycle({4'hC, 4'($random(seed))}, 1'($random(seed)));
    if (int_req !== 1'b1)
      mismatch("int_req cleared by a frehd access");
    io_cycle(8'h1F, 1'($random(seed)));
    if (int_req !== 1'b0)
      mismatch("int_req still high after 1Fh access");
    end_test(6, "interrupt");

    $display("summary: %0d tests, %0d failed, %0d errors", num_tests, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+rtl
+incdir+tb
rtl/trs_bus_pkg.sv
rtl/esp_cmd_pkg.sv
rtl/spi_slave.sv
rtl/cmd_parser.sv
rtl/cmd_exec.sv
rtl/esp_bridge.sv
rtl/trs_io_top.sv
tb/tb_trs_io.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tb_trs_io -o tb_trs_io
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_trs_io)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1
